// File: Bender.yml
package:
  name: boot_system

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/bootPkg.sv
      - src/memPkg.sv
      - src/busIfs.sv
      - src/sdWordReader.sv
      - src/bootLoader.sv
      - src/programRam.sv
      - src/frameBuffer.sv
      - src/memoryRouter.sv
      - src/bootSystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/bootChecker.sv
      - sim/tb_bootSystem.sv

// File: sim/bootChecker.sv
`timescale 1ns/1ps
`include "boot_config.svh"

module bootChecker (
    input  logic                       clk_25mhz,
    input  logic                       reset,
    input  logic                       sdCs,
    input  logic                       sdSclk,
    input  logic                       sdMosi,
    input  logic                       sdMiso,
    input  logic                       busWrite,
    input  logic                       busRead,
    input  memPkg::memWord             busAddr,
    input  memPkg::memWord             busWriteData,
    input  memPkg::memWord             busReadData,
    input  logic                       busReadValid,
    input  logic [`BOOT_FB_X_BITS-1:0] scanX,
    input  logic [`BOOT_FB_Y_BITS-1:0] scanY,
    input  logic [7:0]                 scanColor,
    input  logic                       running,
    input  logic [7:0]                 led,
    output int                         errors,
    output int                         checks
);
    import memPkg::*;

    localparam int RamDepth = 2 ** `BOOT_RAM_ADDR_BITS;
    localparam int PixelCount = 2 ** (`BOOT_FB_X_BITS + `BOOT_FB_Y_BITS);

    // Shadow copies of both memories
    memWord ramShadow [0:RamDepth-1];
    logic [7:0] pixelShadow [0:PixelCount-1];
    logic pixelWritten [0:PixelCount-1];

    // Card traffic as seen on the pins
    logic [71:0] mosiShift;
    memWord misoShift;
    logic inFrame;
    int bitCount;
    int expectedAddr;
    int completed;
    int loadCount;

    logic csPrev;
    logic sclkPrev;
    logic runningPrev;
    logic resetPrev;

    // Read pipeline, two stages like the bus timing
    logic readPipe1;
    logic readPipe2;
    memWord readExp1;
    memWord readExp2;
    string readName1;
    string readName2;

    logic scanPending;
    logic [7:0] scanExp;
    int scanIndex;

    // Led shows the last loaded word once the card is released
    logic ledPending;
    logic [7:0] ledExp;

    initial begin
        errors = 0;
        checks = 0;
        for (int i = 0; i < PixelCount; i++) begin
            pixelWritten[i] = 1'b0;
        end
        csPrev = 1'b1;
        sclkPrev = 1'b0;
        runningPrev = 1'b0;
        resetPrev = 1'b0;
        clearProgress();
    end

    function automatic int pixelIndex(input memWord addr);
        // y in bits 28..24, x in bits 21..16
        return int'({addr[28:24], addr[21:16]});
    endfunction

    // Expected bus read result
    function automatic memWord expectedRead(input memWord addr);
        if (addr[31]) begin
            return {24'h0, pixelShadow[pixelIndex(addr)]};
        end
        return ramShadow[addr[`BOOT_RAM_ADDR_BITS-1:0]];
    endfunction

    task automatic compareValue(input string name, input memWord expected, input memWord actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic reportProblem(input string message);
        errors++;
        $display("%s", message);
    endtask

    task automatic clearProgress();
        inFrame = 1'b0;
        bitCount = 0;
        expectedAddr = 0;
        completed = 0;
        loadCount = 0;
        readPipe1 = 1'b0;
        readPipe2 = 1'b0;
        scanPending = 1'b0;
        ledPending = 1'b0;
    endtask

    task automatic finishTransaction();
        memWord address;
        address = mosiShift[63:32];
        compareValue("spiBitCount", 32'd72, 32'(bitCount));
        compareValue("spiOpcode", 32'h51, {24'h0, mosiShift[71:64]});
        compareValue("spiAddress", 32'(expectedAddr), address);
        // Word 0 is the count, clamped to the RAM depth
        if (address == 0) begin
            loadCount = (misoShift > 32'(RamDepth)) ? RamDepth : int'(misoShift);
        end else if (address <= 32'(loadCount)) begin
            ramShadow[address - 1] = misoShift;
            ledPending = 1'b1;
            ledExp = misoShift[7:0];
        end
        completed++;
        expectedAddr++;
        inFrame = 1'b0;
    endtask

    task automatic watchCard();
        if (ledPending) begin
            compareValue("ledWhileLoading", {24'h0, ledExp}, {24'h0, led});
            ledPending = 1'b0;
        end
        if (!sdCs && csPrev) begin
            if (running) begin
                reportProblem("Card transaction started after boot completed");
            end
            inFrame = 1'b1;
            bitCount = 0;
        end
        if (sdSclk && !sclkPrev) begin
            if (sdCs) begin
                reportProblem("SPI clock rose while chip select was high");
            end
            mosiShift = {mosiShift[70:0], sdMosi};
            misoShift = {misoShift[30:0], sdMiso};
            bitCount++;
        end
        if (sdCs && !csPrev && inFrame) begin
            finishTransaction();
        end
        if (running && !runningPrev) begin
            compareValue("bootTransactions", 32'(loadCount + 1), 32'(completed));
            compareValue("ledAtBoot", 32'h0, {24'h0, led});
        end
    endtask

    task automatic watchBus();
        compareValue("readValidTiming", {31'h0, readPipe2}, {31'h0, busReadValid});
        if (readPipe2 && busReadValid) begin
            compareValue(readName2, readExp2, busReadData);
        end
        readPipe2 = readPipe1;
        readExp2 = readExp1;
        readName2 = readName1;
        readPipe1 = running && busRead;
        if (readPipe1) begin
            readExp1 = expectedRead(busAddr);
            if (busAddr[31]) begin
                readName1 = "pixelRead";
            end else begin
                readName1 = "ramRead";
            end
            compareValue("ledAfterBoot", 32'h0, {24'h0, led});
        end
        // Scan port, one cycle latency
        if (scanPending) begin
            compareValue("scanPort", {24'h0, scanExp}, {24'h0, scanColor});
        end
        scanIndex = int'({scanY, scanX});
        scanPending = pixelWritten[scanIndex];
        scanExp = pixelShadow[scanIndex];
        // Writes land after this edge's reads
        if (running && busWrite) begin
            if (busAddr[31]) begin
                pixelShadow[pixelIndex(busAddr)] = busWriteData[7:0];
                pixelWritten[pixelIndex(busAddr)] = 1'b1;
            end else begin
                ramShadow[busAddr[`BOOT_RAM_ADDR_BITS-1:0]] = busWriteData;
            end
        end
    endtask

    always @(posedge clk_25mhz) begin
        if (reset) begin
            clearProgress();
        end else begin
            if (resetPrev) begin
                // Values right after reset
                compareValue("resetCs", 32'h1, {31'h0, sdCs});
                compareValue("resetSclk", 32'h0, {31'h0, sdSclk});
                compareValue("resetRunning", 32'h0, {31'h0, running});
                compareValue("resetReadValid", 32'h0, {31'h0, busReadValid});
                compareValue("resetLed", 32'h0, {24'h0, led});
            end
            watchCard();
            watchBus();
        end
        csPrev = sdCs;
        sclkPrev = sdSclk;
        runningPrev = running;
        resetPrev = reset;
    end

endmodule

// File: sim/tb_bootSystem.sv
`timescale 1ns/1ps
`include "boot_config.svh"

module tb_bootSystem;
    import memPkg::*;

    localparam int TimeoutCycles = 13 * (146 + 16 + 2) + 2000;
    localparam int ImageWords = 32;

    logic clk_25mhz;
    logic reset;
    logic sdCs;
    logic sdSclk;
    logic sdMosi;
    logic sdMiso;
    logic busWrite;
    logic busRead;
    memWord busAddr;
    memWord busWriteData;
    memWord busReadData;
    logic busReadValid;
    logic [`BOOT_FB_X_BITS-1:0] scanX;
    logic [`BOOT_FB_Y_BITS-1:0] scanY;
    logic [7:0] scanColor;
    logic running;
    logic [7:0] led;

    int checkerErrors;
    int checksRun;
    int tbErrors;
    int cycleCount;
    logic [31:0] lfsrState;
    memWord image [0:ImageWords-1];
    memWord ramAddrs [0:7];
    memWord pixelAddrs [0:7];

    // Card model state
    logic sclkSeen;
    int cardBits;
    logic [39:0] cmdShift;
    logic [39:0] cmdNext;
    memWord dataShift;
    memWord wordOut;

    bootSystem DUT (
        .clk_25mhz(clk_25mhz),
        .reset(reset),
        .sdCs(sdCs),
        .sdSclk(sdSclk),
        .sdMosi(sdMosi),
        .sdMiso(sdMiso),
        .busWrite(busWrite),
        .busRead(busRead),
        .busAddr(busAddr),
        .busWriteData(busWriteData),
        .busReadData(busReadData),
        .busReadValid(busReadValid),
        .scanX(scanX),
        .scanY(scanY),
        .scanColor(scanColor),
        .running(running),
        .led(led)
    );

    bootChecker scoreboard (
        .clk_25mhz(clk_25mhz),
        .reset(reset),
        .sdCs(sdCs),
        .sdSclk(sdSclk),
        .sdMosi(sdMosi),
        .sdMiso(sdMiso),
        .busWrite(busWrite),
        .busRead(busRead),
        .busAddr(busAddr),
        .busWriteData(busWriteData),
        .busReadData(busReadData),
        .busReadValid(busReadValid),
        .scanX(scanX),
        .scanY(scanY),
        .scanColor(scanColor),
        .running(running),
        .led(led),
        .errors(checkerErrors),
        .checks(checksRun)
    );

    always #20 clk_25mhz = ~clk_25mhz;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic writeBus(input memWord addr, input memWord data);
        @(posedge clk_25mhz);
        busWrite <= 1'b1;
        busAddr <= addr;
        busWriteData <= data;
        @(posedge clk_25mhz);
        busWrite <= 1'b0;
        repeat (2) @(posedge clk_25mhz);
    endtask

    task automatic readBus(input memWord addr);
        int waited;
        @(posedge clk_25mhz);
        busRead <= 1'b1;
        busAddr <= addr;
        @(posedge clk_25mhz);
        busRead <= 1'b0;
        waited = 0;
        while (!busReadValid && waited < 8) begin
            @(posedge clk_25mhz);
            waited++;
        end
        if (!busReadValid) begin
            $display("No read response came back for address %h", addr);
            tbErrors++;
        end
        @(posedge clk_25mhz);
    endtask

    // SD card model, mode 0, answers the simplified word read
    always @(posedge clk_25mhz) begin
        sclkSeen <= sdSclk;
        if (reset || sdCs) begin
            cardBits <= 0;
        end else if (sdSclk && !sclkSeen) begin
            cmdNext = {cmdShift[38:0], sdMosi};
            cmdShift <= cmdNext;
            cardBits <= cardBits + 1;
            if (cardBits == 39) begin
                if (cmdNext[39:32] != 8'h51) begin
                    $display("Card model got opcode %h, which is not a word read",
                             cmdNext[39:32]);
                    tbErrors++;
                end
                if (cmdNext[31:0] >= ImageWords) begin
                    $display("Card model got address %h, beyond the card image",
                             cmdNext[31:0]);
                    tbErrors++;
                    wordOut = '0;
                end else begin
                    wordOut = image[cmdNext[4:0]];
                end
                sdMiso <= wordOut[31];
                dataShift <= {wordOut[30:0], 1'b0};
            end else if (cardBits >= 40) begin
                sdMiso <= dataShift[31];
                dataShift <= {dataShift[30:0], 1'b0};
            end
        end
    end

    always @(posedge clk_25mhz) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, the run did not finish", cycleCount);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] value;
        logic [31:0] data;
        clk_25mhz = 1'b0;
        reset = 1'b1;
        sdMiso = 1'b1;
        busWrite = 1'b0;
        busRead = 1'b0;
        busAddr = '0;
        busWriteData = '0;
        scanX = '0;
        scanY = '0;
        sclkSeen = 1'b0;
        cardBits = 0;
        tbErrors = 0;
        cycleCount = 0;
        lfsrState = 32'd84973;
        image[0] = 32'd12;
        for (int i = 1; i < ImageWords; i++) begin
            takeBits(32, value);
            image[i] = value;
        end
        repeat (5) @(posedge clk_25mhz);
        reset <= 1'b0;

        // Reset in the middle of the fifth card read
        repeat (5) @(negedge sdCs);
        repeat (40) @(posedge clk_25mhz);
        reset <= 1'b1;
        repeat (5) @(posedge clk_25mhz);
        reset <= 1'b0;

        while (!running) begin
            @(posedge clk_25mhz);
        end
        repeat (20) @(posedge clk_25mhz);

        // Loaded image
        for (int i = 0; i < 12; i++) begin
            readBus(32'(i));
        end

        // Random RAM writes, then readback
        for (int i = 0; i < 8; i++) begin
            takeBits(`BOOT_RAM_ADDR_BITS, value);
            takeBits(32, data);
            ramAddrs[i] = value;
            writeBus(value, data);
        end
        for (int i = 0; i < 8; i++) begin
            readBus(ramAddrs[i]);
        end

        // Pixels through the bus and the scan port
        for (int i = 0; i < 8; i++) begin
            takeBits(`BOOT_FB_X_BITS, x);
            takeBits(`BOOT_FB_Y_BITS, y);
            takeBits(32, data);
            pixelAddrs[i] = {1'b1, 2'b0, y[4:0], 2'b0, x[5:0], 16'h0};
            writeBus(pixelAddrs[i], data);
            readBus(pixelAddrs[i]);
            @(posedge clk_25mhz);
            scanX <= x[`BOOT_FB_X_BITS-1:0];
            scanY <= y[`BOOT_FB_Y_BITS-1:0];
            repeat (3) @(posedge clk_25mhz);
        end
        for (int i = 0; i < 8; i++) begin
            readBus(pixelAddrs[i]);
        end
        repeat (5) @(posedge clk_25mhz);

        $display("Error count: %0d checker, %0d testbench, %0d checks run",
                 checkerErrors, tbErrors, checksRun);
        if (checkerErrors == 0 && tbErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src/bootLoader.sv
`timescale 1ns/1ps
`include "boot_config.svh"

module bootLoader (
    input  logic                           clk_25mhz,
    input  logic                           reset,
    sdReadIf.master                        sdPort,
    output logic                           ramWrite,
    output logic [`BOOT_RAM_ADDR_BITS-1:0] ramAddr,
    output memPkg::memWord                 ramData,
    output logic                           running,
    output logic [7:0]                     led
);
    import bootPkg::*;

    localparam int CountBits = `BOOT_RAM_ADDR_BITS + 1;
    localparam logic [CountBits-1:0] RamDepth = CountBits'(2 ** `BOOT_RAM_ADDR_BITS);
    localparam int GapBits = $clog2(`BOOT_REQ_GAP + 1);
    localparam logic [GapBits-1:0] GapLast = GapBits'(`BOOT_REQ_GAP - 1);

    loaderState state;
    logic [CountBits-1:0] wordCount;
    // Card word index, one ahead of the RAM address
    logic [CountBits-1:0] wordIndex;
    logic [CountBits-1:0] prevIndex;
    logic [GapBits-1:0] gapCnt;
    logic gapActive;

    assign running = (state == stRunning);
    assign prevIndex = wordIndex - 1'b1;

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            state <= stIdle;
            sdPort.readStrobe <= 1'b0;
            ramWrite <= 1'b0;
            led <= 8'h00;
            wordCount <= '0;
            wordIndex <= '0;
            gapCnt <= '0;
            gapActive <= 1'b0;
        end else begin
            sdPort.readStrobe <= 1'b0;
            ramWrite <= 1'b0;
            case (state)
                stIdle: state <= stReadSize;
                stReadSize: begin
                    if (!sdPort.busy) begin
                        sdPort.readStrobe <= 1'b1;
                        sdPort.wordAddr <= '0;
                        state <= stWaitSize;
                    end
                end
                stWaitSize: begin
                    if (sdPort.done) begin
                        wordIndex <= CountBits'(1);
                        // Clamp the count to the RAM depth
                        if (sdPort.readData > RamDepth) begin
                            wordCount <= RamDepth;
                        end else begin
                            wordCount <= sdPort.readData[CountBits-1:0];
                        end
                        if (sdPort.readData == '0) begin
                            state <= stRunning;
                            led <= 8'h00;
                        end else begin
                            state <= stLoadWord;
                            gapActive <= 1'b1;
                            gapCnt <= '0;
                        end
                    end
                end
                stLoadWord: begin
                    if (gapActive) begin
                        if (wordIndex > wordCount) begin
                            // Last word went to RAM in the previous cycle
                            state <= stRunning;
                            led <= 8'h00;
                            gapActive <= 1'b0;
                        end else if (gapCnt == GapLast) begin
                            if (!sdPort.busy) begin
                                sdPort.readStrobe <= 1'b1;
                                sdPort.wordAddr <= 32'(wordIndex);
                                gapActive <= 1'b0;
                            end
                        end else begin
                            gapCnt <= gapCnt + 1'b1;
                        end
                    end else if (sdPort.done) begin
                        ramWrite <= 1'b1;
                        ramAddr <= prevIndex[`BOOT_RAM_ADDR_BITS-1:0];
                        ramData <= sdPort.readData;
                        led <= sdPort.readData[7:0];
                        wordIndex <= wordIndex + 1'b1;
                        gapActive <= 1'b1;
                        gapCnt <= '0;
                    end
                end
                stRunning: state <= stRunning;
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: src/bootPkg.sv
package bootPkg;

    // Loader sequence
    typedef enum logic [2:0] {
        stIdle,
        stReadSize,
        stWaitSize,
        stLoadWord,
        stRunning
    } loaderState;

    // Simplified card command set
    typedef enum logic [7:0] {
        opNone     = 8'h00,
        opReadWord = 8'h51
    } sdOpcode;

endpackage

// File: src/bootSystem.sv
`timescale 1ns/1ps
`include "boot_config.svh"

module bootSystem (
    input  logic                       clk_25mhz,
    input  logic                       reset,
    output logic                       sdCs,
    output logic                       sdSclk,
    output logic                       sdMosi,
    input  logic                       sdMiso,
    input  logic                       busWrite,
    input  logic                       busRead,
    input  memPkg::memWord             busAddr,
    input  memPkg::memWord             busWriteData,
    output memPkg::memWord             busReadData,
    output logic                       busReadValid,
    input  logic [`BOOT_FB_X_BITS-1:0] scanX,
    input  logic [`BOOT_FB_Y_BITS-1:0] scanY,
    output logic [7:0]                 scanColor,
    output logic                       running,
    output logic [7:0]                 led
);
    import memPkg::*;

    // Loader write path into the router
    logic loaderWrite;
    logic [`BOOT_RAM_ADDR_BITS-1:0] loaderAddr;
    memWord loaderData;

    sdReadIf sdBus ();
    memPortIf ramBus ();
    pixelWriteIf pixelBus ();

    sdWordReader reader (
        .clk_25mhz(clk_25mhz),
        .reset(reset),
        .sdPort(sdBus.reader),
        .sdCs(sdCs),
        .sdSclk(sdSclk),
        .sdMosi(sdMosi),
        .sdMiso(sdMiso)
    );

    bootLoader loader (
        .clk_25mhz(clk_25mhz),
        .reset(reset),
        .sdPort(sdBus.master),
        .ramWrite(loaderWrite),
        .ramAddr(loaderAddr),
        .ramData(loaderData),
        .running(running),
        .led(led)
    );

    memoryRouter router (
        .clk_25mhz(clk_25mhz),
        .reset(reset),
        .running(running),
        .ramWrite(loaderWrite),
        .ramAddr(loaderAddr),
        .ramData(loaderData),
        .busWrite(busWrite),
        .busRead(busRead),
        .busAddr(busAddr),
        .busWriteData(busWriteData),
        .busReadData(busReadData),
        .busReadValid(busReadValid),
        .ramPort(ramBus.master),
        .pixelPort(pixelBus.master)
    );

    programRam ram (
        .clk_25mhz(clk_25mhz),
        .port(ramBus.memory)
    );

    frameBuffer fb (
        .clk_25mhz(clk_25mhz),
        .port(pixelBus.memory),
        .scanX(scanX),
        .scanY(scanY),
        .scanColor(scanColor)
    );

endmodule

// File: src/boot_config.svh
`ifndef BOOT_CONFIG_SVH
`define BOOT_CONFIG_SVH

// Program RAM holds 2**10 words
`define BOOT_RAM_ADDR_BITS 10
// Frame buffer is 64 x 32 pixels
`define BOOT_FB_X_BITS 6
`define BOOT_FB_Y_BITS 5
// System clocks per SPI half period
`define BOOT_SPI_DIV 1
`define BOOT_REQ_GAP 16

`endif

// File: src/busIfs.sv
`timescale 1ns/1ps
`include "boot_config.svh"

// Word read requests from loader to card reader
interface sdReadIf;
    import memPkg::*;

    logic readStrobe;
    memWord wordAddr;
    memWord readData;
    logic busy;
    logic done;

    modport master (output readStrobe, output wordAddr, input readData, input busy, input done);
    modport reader (input readStrobe, input wordAddr, output readData, output busy, output done);
endinterface

// Program RAM port
interface memPortIf;
    import memPkg::*;

    logic writeEnable;
    logic readEnable;
    logic [`BOOT_RAM_ADDR_BITS-1:0] addr;
    memWord writeData;
    memWord readData;

    modport master (output writeEnable, output readEnable, output addr, output writeData,
                    input readData);
    modport memory (input writeEnable, input readEnable, input addr, input writeData,
                    output readData);
endinterface

// Frame buffer bus port
interface pixelWriteIf;
    logic writeEnable;
    logic readEnable;
    logic [`BOOT_FB_X_BITS-1:0] x;
    logic [`BOOT_FB_Y_BITS-1:0] y;
    logic [7:0] color;
    logic [7:0] readColor;

    modport master (output writeEnable, output readEnable, output x, output y, output color,
                    input readColor);
    modport memory (input writeEnable, input readEnable, input x, input y, input color,
                    output readColor);
endinterface

// File: src/frameBuffer.sv
`timescale 1ns/1ps
`include "boot_config.svh"

module frameBuffer (
    input  logic                       clk_25mhz,
    pixelWriteIf.memory                port,
    input  logic [`BOOT_FB_X_BITS-1:0] scanX,
    input  logic [`BOOT_FB_Y_BITS-1:0] scanY,
    output logic [7:0]                 scanColor
);
    localparam int PixelBits = `BOOT_FB_X_BITS + `BOOT_FB_Y_BITS;

    // Row-major, y in the upper index bits
    logic [7:0] pixels [0:(2 ** PixelBits)-1];

    always_ff @(posedge clk_25mhz) begin
        if (port.writeEnable) begin
            pixels[{port.y, port.x}] <= port.color;
        end
        if (port.readEnable) begin
            port.readColor <= pixels[{port.y, port.x}];
        end
    end

    // Display scan port
    always_ff @(posedge clk_25mhz) begin
        scanColor <= pixels[{scanY, scanX}];
    end

endmodule

// File: src/memPkg.sv
package memPkg;

    typedef logic [31:0] memWord;

    // Bus address bit 31 picks the target memory
    typedef enum logic {
        regionRam,
        regionPixel
    } busRegion;

endpackage

// File: src/memoryRouter.sv
`timescale 1ns/1ps
`include "boot_config.svh"

module memoryRouter (
    input  logic                           clk_25mhz,
    input  logic                           reset,
    input  logic                           running,
    input  logic                           ramWrite,
    input  logic [`BOOT_RAM_ADDR_BITS-1:0] ramAddr,
    input  memPkg::memWord                 ramData,
    input  logic                           busWrite,
    input  logic                           busRead,
    input  memPkg::memWord                 busAddr,
    input  memPkg::memWord                 busWriteData,
    output memPkg::memWord                 busReadData,
    output logic                           busReadValid,
    memPortIf.master                       ramPort,
    pixelWriteIf.master                    pixelPort
);
    import memPkg::*;

    busRegion region;
    busRegion regionStage1;
    logic readStage1;

    assign region = busAddr[31] ? regionPixel : regionRam;

    // Loader owns the RAM until the system runs
    assign ramPort.writeEnable = running ? (busWrite && region == regionRam) : ramWrite;
    assign ramPort.readEnable = running && busRead && (region == regionRam);
    assign ramPort.addr = running ? busAddr[`BOOT_RAM_ADDR_BITS-1:0] : ramAddr;
    assign ramPort.writeData = running ? busWriteData : ramData;

    assign pixelPort.writeEnable = running && busWrite && (region == regionPixel);
    assign pixelPort.readEnable = running && busRead && (region == regionPixel);
    assign pixelPort.x = busAddr[16 +: `BOOT_FB_X_BITS];
    assign pixelPort.y = busAddr[24 +: `BOOT_FB_Y_BITS];
    assign pixelPort.color = busWriteData[7:0];

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            readStage1 <= 1'b0;
            busReadValid <= 1'b0;
        end else begin
            readStage1 <= running && busRead;
            busReadValid <= readStage1;
        end
    end

    // Memory results are ready in stage 1
    always_ff @(posedge clk_25mhz) begin
        regionStage1 <= region;
        if (readStage1) begin
            busReadData <= (regionStage1 == regionRam) ? ramPort.readData
                                                       : {24'h0, pixelPort.readColor};
        end
    end

endmodule

// File: src/programRam.sv
`timescale 1ns/1ps
`include "boot_config.svh"

module programRam (
    input logic      clk_25mhz,
    memPortIf.memory port
);
    import memPkg::*;

    localparam int Depth = 2 ** `BOOT_RAM_ADDR_BITS;

    memWord words [0:Depth-1];

    // Write lands at the edge, read data one cycle after the enable
    always_ff @(posedge clk_25mhz) begin
        if (port.writeEnable) begin
            words[port.addr] <= port.writeData;
        end
        if (port.readEnable) begin
            port.readData <= words[port.addr];
        end
    end

endmodule

// File: src/sdWordReader.sv
`timescale 1ns/1ps
`include "boot_config.svh"

module sdWordReader (
    input  logic    clk_25mhz,
    input  logic    reset,
    sdReadIf.reader sdPort,
    output logic    sdCs,
    output logic    sdSclk,
    output logic    sdMosi,
    input  logic    sdMiso
);
    import bootPkg::*;

    // 72 bits, two half periods each
    localparam int HalfPeriods = 144;
    localparam int DivBits = $clog2(`BOOT_SPI_DIV + 1);
    localparam logic [DivBits-1:0] DivLast = DivBits'(`BOOT_SPI_DIV - 1);

    logic [71:0] shiftReg;
    logic [71:0] loadWord;
    logic [7:0] halfCnt;
    logic [DivBits-1:0] divCnt;

    // Opcode, address, then room for the data bits shifted in
    assign loadWord = {opReadWord, sdPort.wordAddr, 32'h0};

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            sdPort.busy <= 1'b0;
            sdPort.done <= 1'b0;
            sdCs <= 1'b1;
            sdSclk <= 1'b0;
            sdMosi <= 1'b1;
            halfCnt <= '0;
            divCnt <= '0;
        end else begin
            sdPort.done <= 1'b0;
            if (!sdPort.busy) begin
                if (sdPort.readStrobe) begin
                    sdPort.busy <= 1'b1;
                    sdCs <= 1'b0;
                    shiftReg <= loadWord;
                    sdMosi <= loadWord[71];
                    halfCnt <= '0;
                    divCnt <= '0;
                end
            end else if (halfCnt < 8'(HalfPeriods)) begin
                if (divCnt == DivLast) begin
                    divCnt <= '0;
                    halfCnt <= halfCnt + 1'b1;
                    if (!halfCnt[0]) begin
                        // Rising edge samples the card
                        sdSclk <= 1'b1;
                        shiftReg <= {shiftReg[70:0], sdMiso};
                    end else begin
                        sdSclk <= 1'b0;
                        sdMosi <= shiftReg[71];
                    end
                end else begin
                    divCnt <= divCnt + 1'b1;
                end
            end else if (halfCnt == 8'(HalfPeriods)) begin
                // Tail cycle, then release the card
                sdCs <= 1'b1;
                sdMosi <= 1'b1;
                sdPort.done <= 1'b1;
                sdPort.readData <= shiftReg[31:0];
                halfCnt <= halfCnt + 1'b1;
            end else begin
                sdPort.busy <= 1'b0;
            end
        end
    end

endmodule

// File: verilog.f
+incdir+src
src/bootPkg.sv
src/memPkg.sv
src/busIfs.sv
src/sdWordReader.sv
src/bootLoader.sv
src/programRam.sv
src/frameBuffer.sv
src/memoryRouter.sv
src/bootSystem.sv
sim/bootChecker.sv
sim/tb_bootSystem.sv
